// File: bench/ldpc_enc_tb.sv
// LDPC encoder engine testbench
// input buffer model with 2-cycle read latency, LFSR block stimulus,
// reference encoder from the code rules, write checks by assertions

`timescale 1ns/100ps

module ldpc_enc_tb
  import ldpc_enc_pkg::*;
();

  localparam int          cCLK_PERIOD   = 40;
  localparam int          cRDAT_DELAY   = 2;
  localparam int          cBLOCKS       = 8;
  localparam int          cBLOCK_CYCLES = 40;
  localparam int          cBLK_WRITES   = cDATA_COLS + cPAR_ROWS;
  localparam logic [31:0] cLFSR_MASK    = 32'ha300_0000;

  typedef zdat_t [cDATA_COLS-1:0] block_t;
  typedef zdat_t [cPAR_ROWS-1:0]  parity_t;

  // one expected output write
  typedef struct packed {
    col_t  addr;
    zdat_t dat;
  } wr_t;

  logic  iclk;
  logic  ireset;
  logic  irbuf_full;
  col_t  oraddr;
  zdat_t irdat;
  logic  orempty;
  logic  iwbuf_empty;
  logic  owrite;
  col_t  owaddr;
  zdat_t owdat;
  logic  owfull;

  block_t      mem;
  zdat_t       rd_stage [cRDAT_DELAY];
  wr_t         exp_q [$];
  logic [31:0] lfsr;
  string       cur_test;
  int          errs;
  int          test_errs0;
  int          tests_run;
  int          tests_ok;
  int          wr_cnt;
  int          rempty_cnt;
  int          full_cnt;

  ldpc_enc_engine #(
    .pRDAT_DELAY (cRDAT_DELAY)
  ) UUT (
    .iclk        (iclk),
    .ireset      (ireset),
    .irbuf_full  (irbuf_full),
    .oraddr      (oraddr),
    .irdat       (irdat),
    .orempty     (orempty),
    .iwbuf_empty (iwbuf_empty),
    .owrite      (owrite),
    .owaddr      (owaddr),
    .owdat       (owdat),
    .owfull      (owfull)
  );

  initial iclk = 1'b0;
  always #(cCLK_PERIOD / 2) iclk = ~iclk;

  //--------------------------------------------------
  // input buffer model
  //--------------------------------------------------

  // one stage per cycle of read latency
  always @(negedge iclk) begin
    irdat = rd_stage[cRDAT_DELAY-1];
    for (int i = cRDAT_DELAY - 1; i > 0; i--) begin
      rd_stage[i] = rd_stage[i-1];
    end
    rd_stage[0] = $isunknown(oraddr) ? '0 : mem[oraddr[1:0]];
  end

  //--------------------------------------------------
  // reference model and stimulus helpers
  //--------------------------------------------------

  function automatic zdat_t rotate_left(zdat_t d, int s);
    zdat_t r;
    for (int i = 0; i < cZC; i++) begin
      r[(i + s) % cZC] = d[i];
    end
    return r;
  endfunction

  // row sums of rotated columns, then the accumulate chain
  function automatic parity_t encode_ref(block_t b);
    zdat_t     acc [cPAR_ROWS];
    parity_t   p;
    hs_entry_t e;
    for (int r = 0; r < cPAR_ROWS; r++) begin
      acc[r] = '0;
    end
    for (int k = 0; k < cCYCLES; k++) begin
      e = cHS_TABLE[k];
      acc[e.row] = acc[e.row] ^ rotate_left(b[e.col], int'(e.shift));
    end
    p[0] = acc[0];
    for (int r = 1; r < cPAR_ROWS; r++) begin
      p[r] = p[r-1] ^ acc[r];
    end
    return p;
  endfunction

  // galois LFSR, one step per bit taken
  task automatic random_block(output block_t b);
    for (int c = 0; c < cDATA_COLS; c++) begin
      for (int i = 0; i < cZC; i++) begin
        b[c][i] = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ cLFSR_MASK) : (lfsr >> 1);
      end
    end
  endtask

  task automatic begin_test(input string name);
    cur_test   = name;
    test_errs0 = errs;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errs == test_errs0) begin
      tests_ok++;
      $display("%s: pass", cur_test);
    end else begin
      $display("%s: %0d errors", cur_test, errs - test_errs0);
    end
  endtask

  // load one block, open both buffers, close them once the input is consumed
  task automatic run_block(input block_t b);
    parity_t p;
    wr_t     w;
    int      wr0;
    int      re0;
    p   = encode_ref(b);
    mem = b;
    for (int c = 0; c < cDATA_COLS; c++) begin
      w.addr = col_t'(c);
      w.dat  = b[c];
      exp_q.push_back(w);
    end
    for (int r = 0; r < cPAR_ROWS; r++) begin
      w.addr = col_t'(cDATA_COLS + r);
      w.dat  = p[r];
      exp_q.push_back(w);
    end
    wr0 = wr_cnt;
    re0 = rempty_cnt;
    @(negedge iclk);
    irbuf_full  = 1'b1;
    iwbuf_empty = 1'b1;
    do @(negedge iclk); while (!orempty);
    irbuf_full  = 1'b0;
    iwbuf_empty = 1'b0;
    while (wr_cnt - wr0 < cBLK_WRITES) @(negedge iclk);
    // quiet tail, catches extra writes
    repeat (4) @(negedge iclk);
    a_blk_writes : assert (wr_cnt - wr0 == cBLK_WRITES) else begin
      errs++;
      $display("Fail %s: writes per block expected %0d actual %0d",
               cur_test, cBLK_WRITES, wr_cnt - wr0);
    end
    a_blk_rempty : assert (rempty_cnt - re0 == 1) else begin
      errs++;
      $display("Fail %s: orempty pulses expected 1 actual %0d", cur_test, rempty_cnt - re0);
    end
    a_blk_drained : assert (exp_q.size() == 0) else begin
      errs++;
      $display("%s: %0d expected writes never arrived", cur_test, exp_q.size());
      exp_q.delete();
    end
  endtask

  //--------------------------------------------------
  // output monitor
  //--------------------------------------------------

  always @(negedge iclk) begin
    wr_t exp_wr;
    if (!ireset) begin
      if (orempty) begin
        rempty_cnt++;
      end
      if (owfull) begin
        full_cnt++;
      end
      a_full_needs_write : assert (!owfull || owrite) else begin
        errs++;
        $display("%s: owfull raised without a write", cur_test);
      end
      if (owrite) begin
        wr_cnt++;
        a_write_expected : assert (exp_q.size() > 0) else begin
          errs++;
          $display("%s: unexpected write to address %0d", cur_test, owaddr);
        end
        if (exp_q.size() > 0) begin
          exp_wr = exp_q.pop_front();
          a_waddr : assert (owaddr == exp_wr.addr) else begin
            errs++;
            $display("Fail %s: write address expected %0d actual %0d",
                     cur_test, exp_wr.addr, owaddr);
          end
          a_wdat : assert (owdat == exp_wr.dat) else begin
            errs++;
            $display("Fail %s: word at address %0d expected %h actual %h",
                     cur_test, exp_wr.addr, exp_wr.dat, owdat);
          end
          // last parity address closes the block
          a_wfull : assert (owfull == (exp_wr.addr == col_t'(cBLK_WRITES - 1))) else begin
            errs++;
            $display("Fail %s: owfull at address %0d expected %b actual %b", cur_test,
                     exp_wr.addr, exp_wr.addr == col_t'(cBLK_WRITES - 1), owfull);
          end
        end
      end
    end
  end

  a_rempty_pulse : assert property (
    @(posedge iclk) disable iff (ireset)
    orempty |=> !orempty
  ) else begin
    errs++;
    $display("%s: orempty stayed high past one cycle", cur_test);
  end

  //--------------------------------------------------
  // watchdog
  //--------------------------------------------------

  initial begin
    #(cBLOCKS * cBLOCK_CYCLES * cCLK_PERIOD);
    $display("timeout: the run did not finish in %0d cycles", cBLOCKS * cBLOCK_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  //--------------------------------------------------
  // test sequence
  //--------------------------------------------------

  initial begin
    block_t blk;
    int     wr0;
    int     re0;
    ireset      = 1'b1;
    irbuf_full  = 1'b0;
    iwbuf_empty = 1'b0;
    irdat       = '0;
    for (int i = 0; i < cRDAT_DELAY; i++) begin
      rd_stage[i] = '0;
    end
    mem         = '0;
    lfsr        = 32'h753d_7a70;
    errs        = 0;
    tests_run   = 0;
    tests_ok    = 0;
    wr_cnt      = 0;
    rempty_cnt  = 0;
    full_cnt    = 0;
    cur_test    = "reset";
    repeat (4) @(negedge iclk);
    ireset = 1'b0;

    begin_test("idle after reset");
    repeat (10) @(negedge iclk);
    a_idle_quiet : assert (wr_cnt == 0 && rempty_cnt == 0 && full_cnt == 0) else begin
      errs++;
      $display("%s: outputs active with both buffers low", cur_test);
    end
    finish_test();

    begin_test("data pass-through");
    random_block(blk);
    run_block(blk);
    finish_test();

    begin_test("random parity");
    for (int n = 0; n < 4; n++) begin
      random_block(blk);
      run_block(blk);
    end
    finish_test();

    begin_test("fixed patterns");
    run_block('1);
    run_block('0);
    finish_test();

    // input full, output buffer busy
    begin_test("output back-pressure");
    random_block(blk);
    mem = blk;
    wr0 = wr_cnt;
    re0 = rempty_cnt;
    irbuf_full = 1'b1;
    repeat (16) @(negedge iclk);
    a_held : assert (wr_cnt == wr0 && rempty_cnt == re0) else begin
      errs++;
      $display("%s: engine ran while the output buffer was busy", cur_test);
    end
    run_block(blk);
    finish_test();

    $display("%0d tests, %0d passed, %0d errors", tests_run, tests_ok, errs);
    if (errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: logic/ldpc_enc_ctrl.sv
// LDPC encoder block controller
// starts a block when input is full and output is free, walks the table,
// waits for the pipeline to drain, then reads out the parity rows

`timescale 1ns/100ps

module ldpc_enc_ctrl
  import ldpc_enc_pkg::*;
#(
  parameter int pRDAT_DELAY = 2
) (
  input  logic       iclk,
  input  logic       ireset,
  input  logic       irbuf_full,
  input  logic       iwbuf_empty,
  output logic       ostart,
  output logic       ocycle_read,
  output cycle_idx_t ocycle_idx,
  output logic       op_read,
  output row_t       op_row,
  output logic       orempty
);

  // read latency + sched register + two rotator stages + accumulator register
  localparam int cDRAIN   = pRDAT_DELAY + 4;
  localparam int cDRAIN_W = $clog2(cDRAIN + 1);

  ctrl_state_t           state;
  cycle_idx_t            cycle_cnt;
  logic [cDRAIN_W-1:0]   drain_cnt;
  row_t                  row_cnt;

  //--------------------------------------------------
  // state machine
  //--------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state     <= IDLE;
      ostart    <= 1'b0;
      cycle_cnt <= '0;
      drain_cnt <= '0;
      row_cnt   <= '0;
    end else begin
      ostart <= 1'b0;
      case (state)
        IDLE: begin
          // block-level back-pressure, both buffers must agree
          if (irbuf_full && iwbuf_empty) begin
            state     <= READ;
            ostart    <= 1'b1;
            cycle_cnt <= '0;
          end
        end
        READ: begin
          if (cycle_cnt == cycle_idx_t'(cCYCLES - 1)) begin
            state     <= DRAIN;
            drain_cnt <= '0;
          end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
          end
        end
        DRAIN: begin
          // last accumulation lands on the final drain cycle
          if (drain_cnt == cDRAIN_W'(cDRAIN - 1)) begin
            state   <= PARITY;
            row_cnt <= '0;
          end else begin
            drain_cnt <= drain_cnt + 1'b1;
          end
        end
        PARITY: begin
          if (row_cnt == row_t'(cPAR_ROWS - 1)) begin
            state <= DONE;
          end else begin
            row_cnt <= row_cnt + 1'b1;
          end
        end
        DONE: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // decoded outputs
  assign ocycle_read = (state == READ);
  assign ocycle_idx  = cycle_cnt;
  assign op_read     = (state == PARITY);
  assign op_row      = row_cnt;
  // input block fully consumed
  assign orempty     = (state == DONE);

  // start is issued on leaving IDLE only
  a_start_from_idle : assert property (
    @(posedge iclk) disable iff (ireset)
    ostart |-> $past(state == IDLE)
  );

endmodule

// File: logic/ldpc_enc_cycle_sched.sv
// LDPC encoder cycle scheduler
// looks up the check table entry, drives the input read address and
// delays the entry so it meets the returned data word

`timescale 1ns/100ps

module ldpc_enc_cycle_sched
  import ldpc_enc_pkg::*;
#(
  parameter int pRDAT_DELAY = 2
) (
  input  logic       iclk,
  input  logic       ireset,
  input  logic       icycle_read,
  input  cycle_idx_t icycle_idx,
  output col_t       oraddr,
  output logic       oval,
  output hs_entry_t  oentry
);

  logic                   entry_val;
  hs_entry_t              entry;
  logic [pRDAT_DELAY-1:0] val_dly;
  hs_entry_t              entry_dly [pRDAT_DELAY];

  //--------------------------------------------------
  // table lookup
  //--------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      entry_val <= 1'b0;
    end else begin
      entry_val <= icycle_read;
    end
  end

  // address holds between reads
  always_ff @(posedge iclk) begin
    if (icycle_read) begin
      entry <= cHS_TABLE[icycle_idx];
    end
  end

  assign oraddr = entry.col;

  //--------------------------------------------------
  // read latency alignment
  //--------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_dly <= '0;
    end else begin
      for (int i = 0; i < pRDAT_DELAY; i++) begin
        val_dly[i] <= (i == 0) ? entry_val : val_dly[i-1];
      end
    end
  end

  always_ff @(posedge iclk) begin
    for (int i = 0; i < pRDAT_DELAY; i++) begin
      entry_dly[i] <= (i == 0) ? entry : entry_dly[i-1];
    end
  end

  assign oval   = val_dly[pRDAT_DELAY-1];
  assign oentry = entry_dly[pRDAT_DELAY-1];

endmodule

// File: logic/ldpc_enc_engine.sv
// LDPC encoder engine top level
// controller, table scheduler, rotator, parity accumulators, output writer

`timescale 1ns/100ps

module ldpc_enc_engine
  import ldpc_enc_pkg::*;
#(
  parameter int pRDAT_DELAY = 2
) (
  input  logic  iclk,
  input  logic  ireset,
  // input buffer side
  input  logic  irbuf_full,
  output col_t  oraddr,
  input  zdat_t irdat,
  output logic  orempty,
  // output buffer side
  input  logic  iwbuf_empty,
  output logic  owrite,
  output col_t  owaddr,
  output zdat_t owdat,
  output logic  owfull
);

  logic       start;
  logic       cycle_read;
  cycle_idx_t cycle_idx;
  logic       p_read;
  row_t       p_row;
  // aligned with irdat
  logic       rd_val;
  hs_entry_t  rd_entry;
  // rotator out
  logic       rot_val;
  zdat_t      rot_dat;
  row_t       rot_row;
  // parity read out
  logic       p_val;
  zdat_t      p_word;

  //--------------------------------------------------
  // stages
  //--------------------------------------------------

  ldpc_enc_ctrl #(
    .pRDAT_DELAY (pRDAT_DELAY)
  ) ctrl (
    .iclk        (iclk),
    .ireset      (ireset),
    .irbuf_full  (irbuf_full),
    .iwbuf_empty (iwbuf_empty),
    .ostart      (start),
    .ocycle_read (cycle_read),
    .ocycle_idx  (cycle_idx),
    .op_read     (p_read),
    .op_row      (p_row),
    .orempty     (orempty)
  );

  ldpc_enc_cycle_sched #(
    .pRDAT_DELAY (pRDAT_DELAY)
  ) sched (
    .iclk        (iclk),
    .ireset      (ireset),
    .icycle_read (cycle_read),
    .icycle_idx  (cycle_idx),
    .oraddr      (oraddr),
    .oval        (rd_val),
    .oentry      (rd_entry)
  );

  ldpc_enc_rotator rot (
    .iclk   (iclk),
    .ireset (ireset),
    .ival   (rd_val),
    .idat   (irdat),
    .ientry (rd_entry),
    .oval   (rot_val),
    .odat   (rot_dat),
    .orow   (rot_row)
  );

  ldpc_enc_parity_acc pacc (
    .iclk    (iclk),
    .ireset  (ireset),
    .istart  (start),
    .ival    (rot_val),
    .irow    (rot_row),
    .idat    (rot_dat),
    .ip_read (p_read),
    .ip_row  (p_row),
    .op_val  (p_val),
    .op_word (p_word)
  );

  ldpc_enc_out_mux mux (
    .iclk    (iclk),
    .ireset  (ireset),
    .istart  (start),
    .ival    (rd_val),
    .ientry  (rd_entry),
    .idat    (irdat),
    .ip_val  (p_val),
    .ip_word (p_word),
    .owrite  (owrite),
    .owaddr  (owaddr),
    .owdat   (owdat),
    .owfull  (owfull)
  );

endmodule

// File: logic/ldpc_enc_out_mux.sv
// LDPC encoder output writer
// passes data words through on first column use, then writes
// chained parity words p_r = p_(r-1) ^ acc_r and flags the last write

`timescale 1ns/100ps

module ldpc_enc_out_mux
  import ldpc_enc_pkg::*;
(
  input  logic      iclk,
  input  logic      ireset,
  input  logic      istart,
  input  logic      ival,
  input  hs_entry_t ientry,
  input  zdat_t     idat,
  input  logic      ip_val,
  input  zdat_t     ip_word,
  output logic      owrite,
  output col_t      owaddr,
  output zdat_t     owdat,
  output logic      owfull
);

  logic  data_wr;
  zdat_t par_run;
  zdat_t par_next;
  row_t  par_cnt;

  // systematic part goes out once per column
  assign data_wr  = ival && ientry.col_first;
  // DVB-style accumulate chain
  assign par_next = par_run ^ ip_word;

  //--------------------------------------------------
  // control
  //--------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      owrite  <= 1'b0;
      owfull  <= 1'b0;
      par_cnt <= '0;
    end else begin
      owrite <= data_wr || ip_val;
      // last parity word closes the block
      owfull <= ip_val && (par_cnt == row_t'(cPAR_ROWS - 1));
      if (istart) begin
        par_cnt <= '0;
      end else if (ip_val) begin
        par_cnt <= par_cnt + 1'b1;
      end
    end
  end

  //--------------------------------------------------
  // write payload
  //--------------------------------------------------

  always_ff @(posedge iclk) begin
    if (istart) begin
      par_run <= '0;
    end else if (ip_val) begin
      par_run <= par_next;
    end
    if (ip_val) begin
      owaddr <= col_t'(cDATA_COLS) + col_t'(par_cnt);
      owdat  <= par_next;
    end else if (data_wr) begin
      owaddr <= ientry.col;
      owdat  <= idat;
    end
  end

  // data phase and parity phase never overlap
  a_no_write_clash : assert property (
    @(posedge iclk) disable iff (ireset)
    !(data_wr && ip_val)
  );

endmodule

// File: logic/ldpc_enc_parity_acc.sv
// LDPC encoder parity accumulators
// one XOR accumulator per check row, cleared at block start,
// with a registered read port for the parity phase

`timescale 1ns/100ps

module ldpc_enc_parity_acc
  import ldpc_enc_pkg::*;
(
  input  logic  iclk,
  input  logic  ireset,
  input  logic  istart,
  input  logic  ival,
  input  row_t  irow,
  input  zdat_t idat,
  input  logic  ip_read,
  input  row_t  ip_row,
  output logic  op_val,
  output zdat_t op_word
);

  zdat_t acc [cPAR_ROWS];

  //--------------------------------------------------
  // accumulation
  //--------------------------------------------------

  always_ff @(posedge iclk) begin
    if (istart) begin
      for (int r = 0; r < cPAR_ROWS; r++) begin
        acc[r] <= '0;
      end
    end else if (ival) begin
      // rotated circulant folds into its row
      acc[irow] <= acc[irow] ^ idat;
    end
  end

  //--------------------------------------------------
  // read port
  //--------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      op_val <= 1'b0;
    end else begin
      op_val <= ip_read;
    end
  end

  // one cycle read latency
  always_ff @(posedge iclk) begin
    if (ip_read) begin
      op_word <= acc[ip_row];
    end
  end

  // parity is read only after every accumulation has landed
  a_read_after_drain : assert property (
    @(posedge iclk) disable iff (ireset)
    ip_read |-> !ival
  );

  // no accumulation may still be in flight at block start
  a_start_quiet : assert property (
    @(posedge iclk) disable iff (ireset)
    istart |-> !ival
  );

endmodule

// File: logic/ldpc_enc_pkg.sv
// LDPC encoder shared definitions
// fixed quasi-cyclic code: 4 data columns, 3 parity rows, 8-bit circulants
// holds sizes, word and index types, controller states and the check table

package ldpc_enc_pkg;

  //--------------------------------------------------
  // code sizes
  //--------------------------------------------------

  // circulant size, one block word
  localparam int cZC        = 8;
  localparam int cDATA_COLS = 4;
  localparam int cPAR_ROWS  = 3;
  // nonzero circulants in the check matrix
  localparam int cCYCLES    = 7;

  //--------------------------------------------------
  // word and index types
  //--------------------------------------------------

  typedef logic [cZC-1:0] zdat_t;

  // data addresses 0..3, parity addresses 4..6
  typedef logic [2:0] col_t;
  typedef logic [1:0] row_t;
  typedef logic [2:0] shift_t;
  typedef logic [2:0] cycle_idx_t;

  // one nonzero circulant of the check matrix
  typedef struct packed {
    col_t   col;
    row_t   row;
    shift_t shift;
    // first entry of its column, data word goes out on it
    logic   col_first;
  } hs_entry_t;

  // block controller states
  typedef enum logic [2:0] {
    IDLE,
    READ,
    DRAIN,
    PARITY,
    DONE
  } ctrl_state_t;

  //--------------------------------------------------
  // parity-check table
  //--------------------------------------------------

  // ordered by column, then by row inside a column
  localparam hs_entry_t cHS_TABLE [cCYCLES] = '{
    // column 0
    '{col: 3'd0, row: 2'd0, shift: 3'd1, col_first: 1'b1},
    '{col: 3'd0, row: 2'd2, shift: 3'd5, col_first: 1'b0},
    // column 1
    '{col: 3'd1, row: 2'd1, shift: 3'd3, col_first: 1'b1},
    // column 2
    '{col: 3'd2, row: 2'd0, shift: 3'd7, col_first: 1'b1},
    '{col: 3'd2, row: 2'd1, shift: 3'd2, col_first: 1'b0},
    // column 3
    '{col: 3'd3, row: 2'd1, shift: 3'd4, col_first: 1'b1},
    '{col: 3'd3, row: 2'd2, shift: 3'd6, col_first: 1'b0}
  };

endpackage

// File: logic/ldpc_enc_rotator.sv
// LDPC encoder circulant rotator
// two-stage cyclic left rotation of one block word, row index rides along

`timescale 1ns/100ps

module ldpc_enc_rotator
  import ldpc_enc_pkg::*;
(
  input  logic      iclk,
  input  logic      ireset,
  input  logic      ival,
  input  zdat_t     idat,
  input  hs_entry_t ientry,
  output logic      oval,
  output zdat_t     odat,
  output row_t      orow
);

  logic  s1_val;
  zdat_t s1_dat;
  logic  s1_hi;
  row_t  s1_row;

  function automatic zdat_t rotl(zdat_t d, int s);
    return (d << s) | (d >> (cZC - s));
  endfunction

  //--------------------------------------------------
  // valid pipe
  //--------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      s1_val <= 1'b0;
      oval   <= 1'b0;
    end else begin
      s1_val <= ival;
      oval   <= s1_val;
    end
  end

  //--------------------------------------------------
  // data pipe
  //--------------------------------------------------

  always_ff @(posedge iclk) begin
    // stage 1 by shift[1:0]
    s1_dat <= rotl(idat, int'(ientry.shift[1:0]));
    s1_hi  <= ientry.shift[2];
    s1_row <= ientry.row;
    // stage 2 by half a word
    odat   <= s1_hi ? rotl(s1_dat, cZC / 2) : s1_dat;
    orow   <= s1_row;
  end

  // table rows must fit the accumulator bank
  a_row_range : assert property (
    @(posedge iclk) disable iff (ireset)
    ival |-> (ientry.row < cPAR_ROWS)
  );

endmodule

// File: sources.f
logic/ldpc_enc_pkg.sv
logic/ldpc_enc_ctrl.sv
logic/ldpc_enc_cycle_sched.sv
logic/ldpc_enc_rotator.sv
logic/ldpc_enc_parity_acc.sv
logic/ldpc_enc_out_mux.sv
logic/ldpc_enc_engine.sv
bench/ldpc_enc_tb.sv
